// ==== include/ahb_defines.svh ====
`ifndef AHB_DEFINES_SVH
`define AHB_DEFINES_SVH

// bus widths
`define AHB_DATA_W 32
`define AHB_ADDR_W 32

// sram region of 4 KiB
// mask marks the offset bits inside the window
`define SRAM_BASE 32'h0000_0000
`define SRAM_MASK 32'h0000_0FFF

// 256 words so the index wraps every 1 KiB inside the window
`define SRAM_DEPTH_WORDS 256

// register block with a 16-byte window
`define REG_BASE 32'h1000_0000
`define REG_MASK 32'h0000_000F

// read-only id word at register 2
`define REG_ID_VALUE 32'h5A17_0C03

// extra cycles of each register data phase (0, 1 or 2)
`define REG_WAIT_STATES 1

`endif

// ==== logic/ahb_pkg.sv ====
`include "ahb_defines.svh"

package ahb_pkg;

    // transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    // master request common to all slaves
    typedef struct packed {
        logic [`AHB_ADDR_W-1:0] haddr;
        htrans_e                htrans;
        logic                   hwrite;
        logic [2:0]             hsize;
        logic [`AHB_DATA_W-1:0] hwdata;
    } ahb_req_t;

    // one slave's answer
    typedef struct packed {
        logic                   hreadyout;
        hresp_e                 hresp;
        logic [`AHB_DATA_W-1:0] hrdata;
    } ahb_rsp_t;

endpackage

// ==== logic/map_pkg.sv ====
package map_pkg;

    localparam int NUM_SLAVES = 3;

    // bit position of each slave in the select vector
    typedef enum logic [1:0] {
        SLV_SRAM    = 2'd0,
        SLV_REG     = 2'd1,
        SLV_DEFAULT = 2'd2
    } slave_id_e;

    // one-hot vector indexed by slave_id_e
    typedef logic [NUM_SLAVES-1:0] hsel_t;

endpackage

// ==== logic/ahb_decoder.sv ====
`include "ahb_defines.svh"

module ahb_decoder (
    input  logic [`AHB_ADDR_W-1:0] haddr,
    output map_pkg::hsel_t         hsel
);

    import map_pkg::*;

    logic sram_hit;
    logic reg_hit;

    // region match on the bits above the window
    assign sram_hit = (haddr & ~`SRAM_MASK) == `SRAM_BASE;
    assign reg_hit  = (haddr & ~`REG_MASK) == `REG_BASE;

    always_comb begin
        hsel = '0;
        if (sram_hit) begin
            hsel[SLV_SRAM] = 1'b1;
        end else if (reg_hit) begin
            hsel[SLV_REG] = 1'b1;
        end else begin
            // everything else goes to the error slave
            hsel[SLV_DEFAULT] = 1'b1;
        end
    end

endmodule

// ==== logic/ahb_slave_mux.sv ====
module ahb_slave_mux (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              hready,
    input  map_pkg::hsel_t    hsel,
    input  ahb_pkg::ahb_rsp_t rsp_sram,
    input  ahb_pkg::ahb_rsp_t rsp_reg,
    input  ahb_pkg::ahb_rsp_t rsp_default,
    output ahb_pkg::ahb_rsp_t rsp
);

    import ahb_pkg::*;
    import map_pkg::*;

    localparam hsel_t SEL_SRAM    = hsel_t'(1) << SLV_SRAM;
    localparam hsel_t SEL_REG     = hsel_t'(1) << SLV_REG;
    localparam hsel_t SEL_DEFAULT = hsel_t'(1) << SLV_DEFAULT;

    hsel_t hsel_q;

    // select of the current data phase
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hsel_q <= '0;
        end else if (hready) begin
            hsel_q <= hsel;
        end
    end

    always_comb begin
        case (hsel_q)
            SEL_SRAM:    rsp = rsp_sram;
            SEL_REG:     rsp = rsp_reg;
            SEL_DEFAULT: rsp = rsp_default;
            // idle bus or bad select
            default:     rsp = '{hreadyout: 1'b1, hresp: OKAY, hrdata: '0};
        endcase
    end

endmodule

// ==== logic/ahb_sram_slave.sv ====
`include "ahb_defines.svh"

module ahb_sram_slave (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              hready,
    input  logic              hsel,
    input  ahb_pkg::ahb_req_t req,
    output ahb_pkg::ahb_rsp_t rsp
);

    import ahb_pkg::*;

    localparam int IDX_W = $clog2(`SRAM_DEPTH_WORDS);

    logic [`AHB_DATA_W-1:0] mem [`SRAM_DEPTH_WORDS];

    logic             accept;
    logic             dp_active;
    logic             dp_write;
    logic [IDX_W-1:0] dp_idx;

    assign accept = hsel && hready && (req.htrans == NONSEQ || req.htrans == SEQ);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            dp_active <= 1'b0;
            dp_write  <= 1'b0;
        end else if (hready) begin
            dp_active <= accept;
            dp_write  <= accept && req.hwrite;
        end
    end

    // word index without the upper window bits
    always_ff @(posedge HCLK) begin
        if (accept) begin
            dp_idx <= req.haddr[IDX_W+1:2];
        end
    end

    // write data arrives one cycle after the address
    always_ff @(posedge HCLK) begin
        if (dp_active && dp_write && hready) begin
            mem[dp_idx] <= req.hwdata;
        end
    end

    always_comb begin
        rsp.hreadyout = 1'b1;
        rsp.hresp     = OKAY;
        if (dp_active && !dp_write) begin
            rsp.hrdata = mem[dp_idx];
        end else begin
            rsp.hrdata = '0;
        end
    end

endmodule

// ==== logic/ahb_reg_slave.sv ====
`include "ahb_defines.svh"

module ahb_reg_slave (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              hready,
    input  logic              hsel,
    input  ahb_pkg::ahb_req_t req,
    output ahb_pkg::ahb_rsp_t rsp
);

    import ahb_pkg::*;

    localparam int WAIT_W = $clog2(`REG_WAIT_STATES + 2);
    localparam logic [WAIT_W-1:0] WAITS = WAIT_W'(`REG_WAIT_STATES);

    logic                   accept;
    logic                   dp_active;
    logic                   dp_write;
    logic [1:0]             dp_sel;
    logic [WAIT_W-1:0]      wait_cnt;
    logic                   do_write;
    logic [`AHB_DATA_W-1:0] scratch0;
    logic [`AHB_DATA_W-1:0] scratch1;
    logic [`AHB_DATA_W-1:0] write_cnt;

    assign accept   = hsel && hready && (req.htrans == NONSEQ || req.htrans == SEQ);
    assign do_write = dp_active && dp_write && (wait_cnt == '0) && hready;

    // data phase tracking and wait-state countdown
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            dp_active <= 1'b0;
            dp_write  <= 1'b0;
            wait_cnt  <= '0;
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else if (hready) begin
            dp_active <= accept;
            dp_write  <= accept && req.hwrite;
            wait_cnt  <= accept ? WAITS : '0;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            dp_sel <= req.haddr[3:2];
        end
    end

    // writes to id and count are dropped but still counted
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            scratch0  <= '0;
            scratch1  <= '0;
            write_cnt <= '0;
        end else if (do_write) begin
            write_cnt <= write_cnt + 1'b1;
            if (dp_sel == 2'd0) begin
                scratch0 <= req.hwdata;
            end else if (dp_sel == 2'd1) begin
                scratch1 <= req.hwdata;
            end
        end
    end

    always_comb begin
        rsp.hreadyout = !(dp_active && wait_cnt != '0);
        rsp.hresp     = OKAY;
        rsp.hrdata    = '0;
        if (dp_active && !dp_write) begin
            case (dp_sel)
                2'd0:    rsp.hrdata = scratch0;
                2'd1:    rsp.hrdata = scratch1;
                2'd2:    rsp.hrdata = `REG_ID_VALUE;
                default: rsp.hrdata = write_cnt;
            endcase
        end
    end

endmodule

// ==== logic/ahb_default_slave.sv ====
module ahb_default_slave (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              hready,
    input  logic              hsel,
    input  ahb_pkg::htrans_e  htrans,
    output ahb_pkg::ahb_rsp_t rsp
);

    import ahb_pkg::*;

    typedef enum logic [1:0] {
        ERR_IDLE,
        ERR_FIRST,
        ERR_SECOND
    } err_state_e;

    err_state_e state;
    logic       accept;

    assign accept = hsel && hready && (htrans == NONSEQ || htrans == SEQ);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state <= ERR_IDLE;
        end else begin
            case (state)
                ERR_IDLE:   state <= accept ? ERR_FIRST : ERR_IDLE;
                ERR_FIRST:  state <= ERR_SECOND;
                // last cycle where a new unmapped transfer may start
                ERR_SECOND: state <= accept ? ERR_FIRST : ERR_IDLE;
                default:    state <= ERR_IDLE;
            endcase
        end
    end

    // two-cycle error with ready low only in the first
    always_comb begin
        rsp.hreadyout = (state != ERR_FIRST);
        rsp.hresp     = (state == ERR_IDLE) ? OKAY : ERROR;
        rsp.hrdata    = '0;
    end

endmodule

// ==== logic/ahb_subsystem_top.sv ====
module ahb_subsystem_top (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  ahb_pkg::ahb_req_t req,
    output logic              hready,
    output ahb_pkg::ahb_rsp_t rsp
);

    import ahb_pkg::*;
    import map_pkg::*;

    hsel_t    hsel;
    ahb_rsp_t rsp_sram;
    ahb_rsp_t rsp_reg;
    ahb_rsp_t rsp_default;

    // bus-wide ready fed back to every slave
    assign hready = rsp.hreadyout;

    ahb_decoder u_decoder (
        .haddr (req.haddr),
        .hsel  (hsel)
    );

    ahb_sram_slave u_sram (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .hready  (hready),
        .hsel    (hsel[SLV_SRAM]),
        .req     (req),
        .rsp     (rsp_sram)
    );

    ahb_reg_slave u_reg (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .hready  (hready),
        .hsel    (hsel[SLV_REG]),
        .req     (req),
        .rsp     (rsp_reg)
    );

    ahb_default_slave u_default (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .hready  (hready),
        .hsel    (hsel[SLV_DEFAULT]),
        .htrans  (req.htrans),
        .rsp     (rsp_default)
    );

    ahb_slave_mux u_mux (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hready      (hready),
        .hsel        (hsel),
        .rsp_sram    (rsp_sram),
        .rsp_reg     (rsp_reg),
        .rsp_default (rsp_default),
        .rsp         (rsp)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic HCLK,
    output logic HRESETn
);

    initial begin
        HCLK = 1'b0;
        forever begin
            #10 HCLK = ~HCLK;
        end
    end

    // reset held low for four rising edges
    initial begin
        HRESETn = 1'b0;
        repeat (4) @(posedge HCLK);
        HRESETn <= 1'b1;
    end

endmodule

// ==== dv/ahb_subsystem_sva.sv ====
module ahb_subsystem_sva (
    input logic              HCLK,
    input logic              HRESETn,
    input ahb_pkg::ahb_req_t req,
    input logic              hready,
    input ahb_pkg::ahb_rsp_t rsp
);

    import ahb_pkg::*;

    // bus comes out of reset ready
    ready_after_reset: assert property (@(posedge HCLK) $rose(HRESETn) |-> hready)
        else $error("hready low in the first cycle after reset");

    // two-cycle error response
    error_second_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (rsp.hresp == ERROR && !hready) |=> (rsp.hresp == ERROR && hready))
        else $error("first error cycle not followed by error with hready high");

    // master holds the request during wait states
    req_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !hready |=> $stable(req))
        else $error("request changed while hready was low");

endmodule

// ==== dv/tb_ahb_subsystem.sv ====
`include "ahb_defines.svh"

module tb_ahb_subsystem;

    import ahb_pkg::*;

    localparam int MAX_WAIT = 10;

    // one table row with stimulus then expected values
    typedef struct packed {
        logic [`AHB_ADDR_W-1:0] haddr;
        logic                   hwrite;
        htrans_e                htrans;
        logic [`AHB_DATA_W-1:0] hwdata;
        logic [`AHB_DATA_W-1:0] exp_rdata;
        logic                   exp_valid;
        hresp_e                 exp_resp;
        logic [3:0]             exp_waits;
    } row_t;

    logic     HCLK;
    logic     HRESETn;
    ahb_req_t req;
    logic     hready;
    ahb_rsp_t rsp;

    row_t                   rows[$];
    logic [`AHB_DATA_W-1:0] sram_model [`SRAM_DEPTH_WORDS];
    logic [`AHB_DATA_W-1:0] scratch_model [2];
    int                     reg_writes = 0;
    int                     data_errors = 0;
    int                     resp_errors = 0;
    int                     wait_errors = 0;
    bit                     timed_out = 1'b0;

    tb_clk_gen u_clk (
        .HCLK    (HCLK),
        .HRESETn (HRESETn)
    );

    ahb_subsystem_top DUT (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .req     (req),
        .hready  (hready),
        .rsp     (rsp)
    );

    bind ahb_subsystem_top ahb_subsystem_sva u_sva (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .req     (req),
        .hready  (hready),
        .rsp     (rsp)
    );

    // expected values follow the address map and the slave rules
    task automatic add_row(input logic [31:0] addr, input logic wr, input htrans_e trans,
                           input logic [31:0] wdata);
        row_t        r;
        logic [31:0] off;
        int          idx;
        r = '0;
        r.haddr = addr;
        r.hwrite = wr;
        r.htrans = trans;
        r.hwdata = wdata;
        r.exp_resp = OKAY;
        if (trans == NONSEQ || trans == SEQ) begin
            if ((addr - `SRAM_BASE) <= `SRAM_MASK) begin
                off = addr - `SRAM_BASE;
                idx = (off >> 2) % `SRAM_DEPTH_WORDS;
                if (wr) begin
                    sram_model[idx] = wdata;
                end else begin
                    r.exp_rdata = sram_model[idx];
                    r.exp_valid = 1'b1;
                end
            end else if ((addr - `REG_BASE) <= `REG_MASK) begin
                off = addr - `REG_BASE;
                idx = (off >> 2) % 4;
                r.exp_waits = `REG_WAIT_STATES;
                if (wr) begin
                    reg_writes++;
                    if (idx < 2) begin
                        scratch_model[idx] = wdata;
                    end
                end else begin
                    r.exp_valid = 1'b1;
                    case (idx)
                        0, 1:    r.exp_rdata = scratch_model[idx];
                        2:       r.exp_rdata = `REG_ID_VALUE;
                        default: r.exp_rdata = reg_writes;
                    endcase
                end
            end else begin
                r.exp_resp = ERROR;
                r.exp_waits = 1;
            end
        end
        rows.push_back(r);
    endtask

    task automatic check_data(input string what, input logic [`AHB_DATA_W-1:0] got,
                              input logic [`AHB_DATA_W-1:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("ERROR at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input hresp_e got, input hresp_e exp);
        if (got !== exp) begin
            resp_errors++;
            $display("ERROR at %0t: %s response %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_waits(input string what, input int got, input int exp);
        if (got != exp) begin
            wait_errors++;
            $display("ERROR at %0t: %s took %0d wait cycles, expected %0d", $time, what, got,
                     exp);
        end
    endtask

    // pipelined master sends the next address with the current write data
    task automatic run_rows();
        row_t  cur;
        row_t  prev;
        int    waits;
        bit    done;
        string what;
        @(posedge HCLK);
        for (int i = 0; i <= rows.size() && !timed_out; i++) begin
            if (i < rows.size()) begin
                cur = rows[i];
                req.haddr  <= cur.haddr;
                req.htrans <= cur.htrans;
                req.hwrite <= cur.hwrite;
                req.hsize  <= 3'b010;
            end else begin
                req.htrans <= IDLE;
                req.hwrite <= 1'b0;
            end
            if (i > 0) begin
                prev = rows[i - 1];
                req.hwdata <= prev.hwdata;
            end
            waits = 0;
            done = 1'b0;
            while (!done && waits < MAX_WAIT) begin
                @(negedge HCLK);
                if (hready) begin
                    done = 1'b1;
                end else begin
                    waits++;
                end
            end
            if (!done) begin
                timed_out = 1'b1;
                $display("timeout: hready stayed low for %0d cycles after row %0d", MAX_WAIT,
                         i);
            end else begin
                if (i > 0) begin
                    what = $sformatf("row %0d addr 0x%08h", i - 1, prev.haddr);
                    check_resp(what, rsp.hresp, prev.exp_resp);
                    check_waits(what, waits, prev.exp_waits);
                    if (prev.exp_valid) begin
                        check_data(what, rsp.hrdata, prev.exp_rdata);
                    end
                end
                @(posedge HCLK);
            end
        end
    endtask

    initial begin
        req = '0;
        void'($urandom(69));
        // sram words at the top of the window and their 1 KiB alias
        add_row(32'h0000_0000, 1'b1, NONSEQ, $urandom);
        add_row(32'h0000_03FC, 1'b1, NONSEQ, $urandom);
        add_row(32'h0000_0000, 1'b0, NONSEQ, 32'h0);
        add_row(32'h0000_03FC, 1'b0, SEQ, 32'h0);
        add_row(32'h0000_0FFC, 1'b1, NONSEQ, $urandom);
        add_row(32'h0000_03FC, 1'b0, NONSEQ, 32'h0);
        add_row(32'h0000_0400, 1'b1, NONSEQ, $urandom);
        add_row(32'h0000_0000, 1'b0, NONSEQ, 32'h0);
        // register block
        add_row(32'h1000_0000, 1'b1, NONSEQ, 32'hCAFE_0001);
        add_row(32'h1000_0004, 1'b1, NONSEQ, 32'h0BAD_F00D);
        add_row(32'h1000_0000, 1'b0, NONSEQ, 32'h0);
        add_row(32'h1000_0004, 1'b0, NONSEQ, 32'h0);
        add_row(32'h1000_0008, 1'b0, NONSEQ, 32'h0);
        add_row(32'h1000_0008, 1'b1, NONSEQ, 32'hFFFF_FFFF);
        add_row(32'h1000_0008, 1'b0, NONSEQ, 32'h0);
        add_row(32'h1000_000C, 1'b0, NONSEQ, 32'h0);
        // unmapped then idle
        add_row(32'h2000_0000, 1'b0, NONSEQ, 32'h0);
        add_row(32'h8000_0010, 1'b1, NONSEQ, 32'h1234_5678);
        add_row(32'h3000_0000, 1'b0, IDLE, 32'h0);
        add_row(32'h0000_0000, 1'b0, NONSEQ, 32'h0);
        // mixed slaves back to back
        add_row(32'h0000_0010, 1'b1, NONSEQ, $urandom);
        add_row(32'h1000_0004, 1'b1, NONSEQ, 32'h0000_00A5);
        add_row(32'h0000_0010, 1'b0, NONSEQ, 32'h0);
        add_row(32'h1000_0004, 1'b0, NONSEQ, 32'h0);
        add_row(32'h4000_0000, 1'b0, NONSEQ, 32'h0);
        add_row(32'h1000_000C, 1'b0, NONSEQ, 32'h0);
        for (int n = 0; n < 20 && HRESETn !== 1'b1; n++) begin
            @(posedge HCLK);
        end
        if (HRESETn !== 1'b1) begin
            timed_out = 1'b1;
            $display("reset was never released");
        end else begin
            run_rows();
        end
        $display("data errors: %0d, response errors: %0d, wait errors: %0d, timeout: %0d",
                 data_errors, resp_errors, wait_errors, timed_out);
        if (data_errors == 0 && resp_errors == 0 && wait_errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
logic/ahb_pkg.sv
logic/map_pkg.sv
logic/ahb_decoder.sv
logic/ahb_slave_mux.sv
logic/ahb_sram_slave.sv
logic/ahb_reg_slave.sv
logic/ahb_default_slave.sv
logic/ahb_subsystem_top.sv
dv/tb_clk_gen.sv
dv/ahb_subsystem_sva.sv
dv/tb_ahb_subsystem.sv
